/* Bender.yml */
package:
  name: led_status

sources:
  - led_status_pkg.sv
  - led_status_regs.sv
  - led_err_blinker.sv
  - led_display_mux.sv
  - led_status_top.sv
  - target: simulation
    files:
      - led_status_checker.sv
      - led_status_tb.sv

/* led_display_mux.sv */
`timescale 1ns/1ps

module led_display_mux #(
  parameter int LED_CHANNELS = 4
) (
  input  logic                                          clock,
  input  logic                                          arst_n,
  input  led_status_pkg::led_frame_t [LED_CHANNELS-1:0] frames,
  input  logic [LED_CHANNELS-1:0]                       flags,
  input  led_status_pkg::chan_sel_t                     sel,
  output led_status_pkg::led_frame_t                    leds,
  output logic                                          err_any
);

  import led_status_pkg::*;

  led_frame_t sel_frame;

  // --------------------------------------------------------------------------
  // Channel select
  // --------------------------------------------------------------------------

  // A select past the last channel shows a dark bank
  always_comb begin
    if (int'(sel) < LED_CHANNELS) begin
      sel_frame = frames[sel];
    end else begin
      sel_frame = '0;
    end
  end

  // Output stage for the LED drivers and summary lamp
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      leds    <= '0;
      err_any <= 1'b0;
    end else begin
      leds    <= sel_frame;
      // Any channel in error
      err_any <= |flags;
    end
  end

endmodule

/* led_err_blinker.sv */
`timescale 1ns/1ps

module led_err_blinker #(
  parameter int PRESCALE_WIDTH = 24
) (
  input  logic                        clock,
  input  logic                        arst_n,
  input  logic                        err,
  input  logic                        clear,
  input  led_status_pkg::blink_rate_t rate,
  output logic                        flag,
  output led_status_pkg::led_frame_t  frame
);

  // One extra bit catches the prescaler carry
  localparam int SUM_WIDTH = PRESCALE_WIDTH + 1;

  logic [PRESCALE_WIDTH-1:0] prescaler;
  logic [SUM_WIDTH-1:0]      pre_sum;
  logic                      step;
  logic                      phase;

  // --------------------------------------------------------------------------
  // Sticky error flag
  // --------------------------------------------------------------------------

  // Error wins over a clear in the same cycle
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      flag <= 1'b0;
    end else if (err) begin
      flag <= 1'b1;
    end else if (clear) begin
      flag <= 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // Rate-scaled prescaler
  // --------------------------------------------------------------------------

  // Step of rate+1, so rate 3 blinks four times as fast as rate 0
  assign pre_sum = SUM_WIDTH'(prescaler) + SUM_WIDTH'(rate) + SUM_WIDTH'(1);

  // Blink step on each carry out
  assign step = flag & pre_sum[PRESCALE_WIDTH];

  // Prescaler and phase park at zero while idle
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      prescaler <= '0;
      phase     <= 1'b0;
    end else if (!flag) begin
      prescaler <= '0;
      phase     <= 1'b0;
    end else begin
      prescaler <= pre_sum[PRESCALE_WIDTH-1:0];
      // Two-phase pattern, off then on
      if (step) begin
        phase <= ~phase;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Frame output
  // --------------------------------------------------------------------------

  // All on in phase one, all off otherwise or with no error
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      frame <= '0;
    end else if (flag && phase) begin
      frame <= '1;
    end else begin
      frame <= '0;
    end
  end

endmodule

/* led_status_checker.sv */
`timescale 1ns/1ps

module led_status_checker #(
  parameter bit BUS_SIDE = 1'b1
) (
  input logic                       clock,
  input logic                       arst_n,
  input led_status_pkg::axil_req_t  axil_req,
  input led_status_pkg::axil_rsp_t  axil_rsp,
  input led_status_pkg::led_frame_t leds
);

  // Failed assertion count, read by the testbench at the end
  int fails = 0;

  if (BUS_SIDE) begin : g_bus

    // ------------------------------------------------------------------------
    // AXI-Lite handshake
    // ------------------------------------------------------------------------

    // Write response stays up until the master takes it
    a_bvalid_held: assert property (@(posedge clock) disable iff (!arst_n)
      axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
      else begin
        fails++;
        $error("bvalid dropped before bready");
      end

    // Read data stays up until the master takes it
    a_rvalid_held: assert property (@(posedge clock) disable iff (!arst_n)
      axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
      else begin
        fails++;
        $error("rvalid dropped before rready");
      end

    // No handshake output while the bus is in reset
    a_quiet_in_reset: assert property (@(posedge clock)
      !arst_n |-> !(axil_rsp.awready || axil_rsp.wready || axil_rsp.bvalid ||
                    axil_rsp.arready || axil_rsp.rvalid))
      else begin
        fails++;
        $error("handshake output high during reset");
      end

  end else begin : g_leds

    // ------------------------------------------------------------------------
    // LED bank
    // ------------------------------------------------------------------------

    // Bank is either dark or fully lit
    a_leds_solid: assert property (@(posedge clock) disable iff (!arst_n)
      (leds == '0) || (leds == '1))
      else begin
        fails++;
        $error("LED frame neither all-off nor all-on");
      end

  end

endmodule

// Handshake checks on the register block
bind led_status_regs led_status_checker #(
  .BUS_SIDE (1'b1)
) u_regs_checker (
  .clock    (clock),
  .arst_n   (arst_n),
  .axil_req (axil_req),
  .axil_rsp (axil_rsp),
  .leds     ('0)
);

// Frame checks on the display mux
bind led_display_mux led_status_checker #(
  .BUS_SIDE (1'b0)
) u_mux_checker (
  .clock    (clock),
  .arst_n   (arst_n),
  .axil_req ('0),
  .axil_rsp ('0),
  .leds     (leds)
);

/* led_status_pkg.sv */
package led_status_pkg;

  // --------------------------------------------------------------------------
  // Widths that carry a meaning
  // --------------------------------------------------------------------------

  // One frame of the 16-LED front-panel bank
  typedef logic [15:0] led_frame_t;
  // Blink rate code, higher is faster
  typedef logic [1:0]  blink_rate_t;
  // Channel index shown on the LED bank
  typedef logic [1:0]  chan_sel_t;
  // Byte address inside the register space
  typedef logic [3:0]  axil_addr_t;
  typedef logic [31:0] axil_data_t;

  // Register map
  localparam axil_addr_t REG_RATE   = 4'h0;
  localparam axil_addr_t REG_SELECT = 4'h4;
  localparam axil_addr_t REG_STATUS = 4'h8;

  // AXI response codes
  localparam logic [1:0] AXIL_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXIL_RESP_SLVERR = 2'b10;

  // --------------------------------------------------------------------------
  // AXI4-Lite channels, write strobes not carried
  // --------------------------------------------------------------------------

  // Master-driven signals
  typedef struct packed {
    axil_addr_t awaddr;
    logic       awvalid;
    axil_data_t wdata;
    logic       wvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       rready;
  } axil_req_t;

  // Slave-driven signals
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       arready;
    axil_data_t rdata;
    logic [1:0] rresp;
    logic       rvalid;
  } axil_rsp_t;

  // Write path FSM
  typedef enum logic {
    WR_IDLE,
    WR_RESP
  } axil_wr_state_t;

endpackage

/* led_status_regs.sv */
`timescale 1ns/1ps

module led_status_regs #(
  parameter int LED_CHANNELS = 4
) (
  input  logic                                           clock,
  input  logic                                           arst_n,
  input  led_status_pkg::axil_req_t                      axil_req,
  output led_status_pkg::axil_rsp_t                      axil_rsp,
  input  logic [LED_CHANNELS-1:0]                        err_flags,
  output led_status_pkg::blink_rate_t [LED_CHANNELS-1:0] rates,
  output led_status_pkg::chan_sel_t                      display_sel,
  output logic [LED_CHANNELS-1:0]                        err_clear
);

  import led_status_pkg::*;

  // --------------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------------

  // True for the three implemented offsets
  function automatic logic addr_valid(axil_addr_t addr);
    logic hit;
    case (addr)
      REG_RATE:   hit = 1'b1;
      REG_SELECT: hit = 1'b1;
      REG_STATUS: hit = 1'b1;
      default:    hit = 1'b0;
    endcase
    return hit;
  endfunction

  // Write path state
  axil_wr_state_t wr_state;
  logic           wr_accept;
  logic [1:0]     bresp_q;

  // Read path state
  logic           rd_accept;
  logic           rvalid_q;
  axil_data_t     rd_word;
  axil_data_t     rdata_q;
  logic [1:0]     rresp_q;

  // Address and data taken together, only with no response pending
  assign wr_accept = (wr_state == WR_IDLE) && axil_req.awvalid && axil_req.wvalid;

  // One read in flight at a time
  assign rd_accept = axil_req.arvalid && !rvalid_q;

  // Response channel outputs
  always_comb begin
    axil_rsp.awready = wr_accept;
    axil_rsp.wready  = wr_accept;
    axil_rsp.bvalid  = (wr_state == WR_RESP);
    axil_rsp.bresp   = bresp_q;
    axil_rsp.arready = rd_accept;
    axil_rsp.rvalid  = rvalid_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp_q;
  end

  // --------------------------------------------------------------------------
  // Write path
  // --------------------------------------------------------------------------

  // Register update lands together with bvalid
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      wr_state    <= WR_IDLE;
      rates       <= '0;
      display_sel <= '0;
      err_clear   <= '0;
    end else begin
      // Clear vector is a one-cycle pulse
      err_clear <= '0;
      case (wr_state)
        WR_IDLE: begin
          if (wr_accept) begin
            wr_state <= WR_RESP;
            case (axil_req.awaddr)
              REG_RATE:   rates       <= axil_req.wdata[2*LED_CHANNELS-1:0];
              REG_SELECT: display_sel <= axil_req.wdata[$bits(chan_sel_t)-1:0];
              // Write-one-to-clear on the sticky flags
              REG_STATUS: err_clear   <= axil_req.wdata[LED_CHANNELS-1:0];
              // Unmapped offset, nothing changes
              default: ;
            endcase
          end
        end
        WR_RESP: begin
          // Hold the response until the master takes it
          if (axil_req.bready) begin
            wr_state <= WR_IDLE;
          end
        end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  // Write response code
  always_ff @(posedge clock) begin
    if (wr_accept) begin
      bresp_q <= addr_valid(axil_req.awaddr) ? AXIL_RESP_OKAY : AXIL_RESP_SLVERR;
    end
  end

  // --------------------------------------------------------------------------
  // Read path
  // --------------------------------------------------------------------------

  // Read data mux, zero outside the map
  always_comb begin
    rd_word = '0;
    case (axil_req.araddr)
      REG_RATE:   rd_word[2*LED_CHANNELS-1:0]     = rates;
      REG_SELECT: rd_word[$bits(chan_sel_t)-1:0]  = display_sel;
      REG_STATUS: rd_word[LED_CHANNELS-1:0]       = err_flags;
      default:    rd_word                         = '0;
    endcase
  end

  // rvalid one cycle after arready, held until rready
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rvalid_q <= 1'b0;
    end else if (rd_accept) begin
      rvalid_q <= 1'b1;
    end else if (axil_req.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // Read payload captured at the address handshake
  always_ff @(posedge clock) begin
    if (rd_accept) begin
      rdata_q <= rd_word;
      rresp_q <= addr_valid(axil_req.araddr) ? AXIL_RESP_OKAY : AXIL_RESP_SLVERR;
    end
  end

endmodule

/* led_status_tb.sv */
`timescale 1ns/1ps

module led_status_tb;

  import led_status_pkg::*;

  localparam int CHANNELS        = 4;
  localparam int PRESCALE_W      = 6;
  localparam int N_ITER          = 16;
  // Two blink half periods at the slowest rate plus pipeline slack
  localparam int BLINK_WINDOW    = 2 * (1 << PRESCALE_W) + 4;
  localparam int HS_LIMIT        = 50;
  localparam int WATCHDOG_CYCLES = N_ITER * 4 * (1 << PRESCALE_W) + 4000;

  logic                clock;
  logic                arst_n;
  axil_req_t           axil_req;
  axil_rsp_t           axil_rsp;
  logic [CHANNELS-1:0] err_in;
  led_frame_t          leds;
  logic                err_any;

  integer seed;
  int     errors;
  int     checks;
  int     assert_fails;

  // Model of the register state
  logic [2*CHANNELS-1:0] exp_rates;
  chan_sel_t             exp_sel;
  logic [CHANNELS-1:0]   exp_flags;

  led_status_top #(
    .LED_CHANNELS   (CHANNELS),
    .PRESCALE_WIDTH (PRESCALE_W)
  ) u_led_status_top (
    .clock    (clock),
    .arst_n   (arst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .err_in   (err_in),
    .leds     (leds),
    .err_any  (err_any)
  );

  always #5 clock = ~clock;

  // --------------------------------------------------------------------------
  // Reporting and bus tasks
  // --------------------------------------------------------------------------

  task automatic report_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    errors++;
  endtask

  // Drives address and data together and waits for the response
  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            output logic [1:0] resp);
    int wait_cnt;
    wait_cnt = 0;
    @(posedge clock);
    axil_req.awaddr  <= addr;
    axil_req.awvalid <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wvalid  <= 1'b1;
    axil_req.bready  <= 1'b1;
    @(negedge clock);
    while (!(axil_rsp.awready && axil_rsp.wready) && wait_cnt < HS_LIMIT) begin
      @(negedge clock);
      wait_cnt++;
    end
    @(posedge clock);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    @(negedge clock);
    while (!axil_rsp.bvalid && wait_cnt < HS_LIMIT) begin
      @(negedge clock);
      wait_cnt++;
    end
    resp = axil_rsp.bresp;
    @(posedge clock);
    axil_req.bready <= 1'b0;
    if (wait_cnt >= HS_LIMIT) begin
      $display("AXI-Lite write to 0x%0h never completed its handshake", addr);
      errors++;
    end
  endtask

  task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                           output logic [1:0] resp);
    int wait_cnt;
    wait_cnt = 0;
    @(posedge clock);
    axil_req.araddr  <= addr;
    axil_req.arvalid <= 1'b1;
    axil_req.rready  <= 1'b1;
    @(negedge clock);
    while (!axil_rsp.arready && wait_cnt < HS_LIMIT) begin
      @(negedge clock);
      wait_cnt++;
    end
    @(posedge clock);
    axil_req.arvalid <= 1'b0;
    @(negedge clock);
    while (!axil_rsp.rvalid && wait_cnt < HS_LIMIT) begin
      @(negedge clock);
      wait_cnt++;
    end
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(posedge clock);
    axil_req.rready <= 1'b0;
    if (wait_cnt >= HS_LIMIT) begin
      $display("AXI-Lite read from 0x%0h never completed its handshake", addr);
      errors++;
    end
  endtask

  task automatic expect_write(input axil_addr_t addr, input axil_data_t data,
                              input logic [1:0] exp_resp);
    logic [1:0] resp;
    axil_write(addr, data, resp);
    checks++;
    if (resp !== exp_resp) begin
      report_error($sformatf("write 0x%0h resp %0d, expected %0d", addr, resp, exp_resp));
    end
  endtask

  task automatic expect_read(input axil_addr_t addr, input axil_data_t exp_data,
                             input logic [1:0] exp_resp);
    axil_data_t data;
    logic [1:0] resp;
    axil_read(addr, data, resp);
    checks++;
    if (data !== exp_data || resp !== exp_resp) begin
      report_error($sformatf("read 0x%0h gave 0x%0h resp %0d, expected 0x%0h resp %0d",
                             addr, data, resp, exp_data, exp_resp));
    end
  endtask

  // --------------------------------------------------------------------------
  // Error sources and LED observation
  // --------------------------------------------------------------------------

  // One-cycle error pulse on the masked channels
  task automatic pulse_err(input logic [CHANNELS-1:0] mask);
    @(posedge clock);
    err_in <= mask;
    @(posedge clock);
    err_in <= '0;
  endtask

  // Summary lamp lags the flags by up to two cycles
  task automatic check_err_any();
    repeat (2) @(posedge clock);
    @(negedge clock);
    checks++;
    if (err_any !== (|exp_flags)) begin
      report_error($sformatf("err_any %b with model flags %b", err_any, exp_flags));
    end
  endtask

  task automatic watch_leds(input int cycles, output logic saw_on, output logic saw_off,
                            output logic saw_other);
    saw_on    = 1'b0;
    saw_off   = 1'b0;
    saw_other = 1'b0;
    repeat (cycles) begin
      @(negedge clock);
      if (leds === '1) begin
        saw_on = 1'b1;
      end else if (leds === '0) begin
        saw_off = 1'b1;
      end else begin
        saw_other = 1'b1;
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial begin
    int                  i;
    int                  c;
    int                  op;
    axil_data_t          wdata;
    logic [CHANNELS-1:0] mask;
    logic [CHANNELS-1:0] hold;
    logic [CHANNELS-1:0] pattern;
    logic [1:0]          rate;
    logic                saw_on;
    logic                saw_off;
    logic                saw_other;
    clock     = 1'b0;
    arst_n    = 1'b1;
    axil_req  = '0;
    err_in    = '0;
    seed      = 32'hffa9_9231;
    errors    = 0;
    checks    = 0;
    exp_rates = '0;
    exp_sel   = '0;
    exp_flags = '0;
    #1;
    arst_n = 1'b0;
    repeat (10) @(posedge clock);
    arst_n <= 1'b1;

    // Register readback and the unmapped offset
    for (i = 0; i < N_ITER; i++) begin
      wdata = $random(seed);
      op    = $unsigned($random(seed)) % 3;
      if (op == 0) begin
        expect_write(REG_RATE, wdata, AXIL_RESP_OKAY);
        exp_rates = wdata[2*CHANNELS-1:0];
      end else if (op == 1) begin
        expect_write(REG_SELECT, wdata, AXIL_RESP_OKAY);
        exp_sel = wdata[1:0];
      end else begin
        expect_write(4'hC, wdata, AXIL_RESP_SLVERR);
        expect_read(4'hC, '0, AXIL_RESP_SLVERR);
      end
      expect_read(REG_RATE, axil_data_t'(exp_rates), AXIL_RESP_OKAY);
      expect_read(REG_SELECT, axil_data_t'(exp_sel), AXIL_RESP_OKAY);
    end

    // Sticky set and write-one-to-clear with an occasional held error
    for (i = 0; i < N_ITER; i++) begin
      mask = CHANNELS'($random(seed));
      pulse_err(mask);
      exp_flags = exp_flags | mask;
      expect_read(REG_STATUS, axil_data_t'(exp_flags), AXIL_RESP_OKAY);
      check_err_any();
      mask = CHANNELS'($random(seed));
      hold = '0;
      if ($unsigned($random(seed)) % 4 == 0) begin
        hold[$unsigned($random(seed)) % CHANNELS] = 1'b1;
      end
      @(posedge clock);
      err_in <= hold;
      expect_write(REG_STATUS, axil_data_t'(mask), AXIL_RESP_OKAY);
      @(posedge clock);
      err_in <= '0;
      // Error beats clear on the held channel
      exp_flags = (exp_flags & ~mask) | hold;
      expect_read(REG_STATUS, axil_data_t'(exp_flags), AXIL_RESP_OKAY);
      check_err_any();
    end
    expect_write(REG_STATUS, '1, AXIL_RESP_OKAY);
    exp_flags = '0;
    check_err_any();

    // Blink on the selected channel at every rate
    c = $unsigned($random(seed)) % CHANNELS;
    expect_write(REG_SELECT, axil_data_t'(c), AXIL_RESP_OKAY);
    exp_sel = chan_sel_t'(c);
    pulse_err(CHANNELS'(1) << c);
    exp_flags[c] = 1'b1;
    for (i = 0; i < 4; i++) begin
      rate = 2'(i);
      expect_write(REG_RATE, axil_data_t'({CHANNELS{rate}}), AXIL_RESP_OKAY);
      exp_rates = {CHANNELS{rate}};
      watch_leds(BLINK_WINDOW, saw_on, saw_off, saw_other);
      checks++;
      if (!saw_on || !saw_off || saw_other) begin
        report_error($sformatf("rate %0d on channel %0d: on %b off %b other %b",
                               rate, c, saw_on, saw_off, saw_other));
      end
    end
    expect_write(REG_STATUS, axil_data_t'(CHANNELS'(1) << c), AXIL_RESP_OKAY);
    exp_flags[c] = 1'b0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    checks++;
    if (leds !== '0) begin
      report_error($sformatf("leds 0x%0h after flag clear, expected all-off", leds));
    end

    // Only the selected channel of a mixed flag pattern reaches the bank
    pattern = CHANNELS'($random(seed));
    if (pattern == '0 || pattern == '1) begin
      pattern    = '0;
      pattern[0] = 1'b1;
    end
    expect_write(REG_RATE, axil_data_t'({CHANNELS{2'd3}}), AXIL_RESP_OKAY);
    exp_rates = {CHANNELS{2'd3}};
    pulse_err(pattern);
    exp_flags = pattern;
    for (c = 0; c < CHANNELS; c++) begin
      expect_write(REG_SELECT, axil_data_t'(c), AXIL_RESP_OKAY);
      exp_sel = chan_sel_t'(c);
      repeat (2) @(posedge clock);
      watch_leds(BLINK_WINDOW, saw_on, saw_off, saw_other);
      checks++;
      if (exp_flags[c] && (!saw_on || !saw_off || saw_other)) begin
        report_error($sformatf("channel %0d in error did not blink on the bank", c));
      end else if (!exp_flags[c] && (saw_on || saw_other)) begin
        report_error($sformatf("channel %0d without error lit the bank", c));
      end
    end
    expect_write(REG_STATUS, '1, AXIL_RESP_OKAY);
    exp_flags = '0;
    check_err_any();

    assert_fails = u_led_status_top.u_led_status_regs.u_regs_checker.fails +
                   u_led_status_top.u_led_display_mux.u_mux_checker.fails;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog against a stuck handshake or a lost blink
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("Watchdog expired after %0d cycles, the test did not finish", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

/* led_status_top.sv */
`timescale 1ns/1ps

module led_status_top #(
  parameter int LED_CHANNELS   = 4,
  parameter int PRESCALE_WIDTH = 24
) (
  input  logic                       clock,
  input  logic                       arst_n,
  input  led_status_pkg::axil_req_t  axil_req,
  output led_status_pkg::axil_rsp_t  axil_rsp,
  input  logic [LED_CHANNELS-1:0]    err_in,
  output led_status_pkg::led_frame_t leds,
  output logic                       err_any
);

  import led_status_pkg::*;

  // --------------------------------------------------------------------------
  // Internal wiring
  // --------------------------------------------------------------------------

  // Per-channel rate codes from the register block
  blink_rate_t [LED_CHANNELS-1:0] rates;
  // Channel shown on the LED bank
  chan_sel_t                      display_sel;
  // Write-one-to-clear pulses
  logic [LED_CHANNELS-1:0]        err_clear;
  // Sticky flags back to STATUS and the mux
  logic [LED_CHANNELS-1:0]        err_flags;
  // Blink frames of all channels
  led_frame_t [LED_CHANNELS-1:0]  frames;

  // Host register block
  led_status_regs #(
    .LED_CHANNELS (LED_CHANNELS)
  ) u_led_status_regs (
    .clock       (clock),
    .arst_n      (arst_n),
    .axil_req    (axil_req),
    .axil_rsp    (axil_rsp),
    .err_flags   (err_flags),
    .rates       (rates),
    .display_sel (display_sel),
    .err_clear   (err_clear)
  );

  // --------------------------------------------------------------------------
  // One blinker per error source
  // --------------------------------------------------------------------------

  for (genvar i = 0; i < LED_CHANNELS; i++) begin : g_chan
    led_err_blinker #(
      .PRESCALE_WIDTH (PRESCALE_WIDTH)
    ) u_led_err_blinker (
      .clock  (clock),
      .arst_n (arst_n),
      .err    (err_in[i]),
      .clear  (err_clear[i]),
      .rate   (rates[i]),
      .flag   (err_flags[i]),
      .frame  (frames[i])
    );
  end

  // Frame select onto the panel
  led_display_mux #(
    .LED_CHANNELS (LED_CHANNELS)
  ) u_led_display_mux (
    .clock   (clock),
    .arst_n  (arst_n),
    .frames  (frames),
    .flags   (err_flags),
    .sel     (display_sel),
    .leds    (leds),
    .err_any (err_any)
  );

endmodule

/* sim.f */
led_status_pkg.sv
led_status_regs.sv
led_err_blinker.sv
led_display_mux.sv
led_status_top.sv
led_status_checker.sv
led_status_tb.sv
